//--- ntm_dot_accumulator.sv
// Dot product accumulator
// Multiply-accumulate register, all arithmetic wraps modulo 2^DATA_SIZE.
// Clear restarts the sum, and with enable loads the first product directly

module ntm_dot_accumulator #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 clear,
  input  logic                 enable,

  // Operands
  input  logic [DATA_SIZE-1:0] data_a_in,
  input  logic [DATA_SIZE-1:0] data_b_in,

  // Running sum
  output logic [DATA_SIZE-1:0] sum
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Low half of the product only
  logic [DATA_SIZE-1:0] product;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // Truncates to DATA_SIZE bits by assignment width
  assign product = data_a_in * data_b_in;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum <= '0;
    end else if (clear) begin
      // New row, no bubble when a word comes with the clear
      if (enable) begin
        sum <= product;
      end else begin
        sum <= '0;
      end
    end else if (enable) begin
      // Wraps on overflow
      sum <= sum + product;
    end
  end

endmodule

//--- ntm_matrix_vector_product.sv
// Matrix-vector product over streamed words
// Buffers a vector of columns words, then takes matrix rows word by word
// and emits one wrapped dot product per row

module ntm_matrix_vector_product #(
  parameter int DATA_SIZE  = 16,
  parameter int MAX_LENGTH = 16
) (
  input  logic                                  CLK,
  input  logic                                  RST,

  // Control
  input  logic                                  start,
  input  logic [ntm_output_pkg::SIZE_WIDTH-1:0] rows,
  input  logic [ntm_output_pkg::SIZE_WIDTH-1:0] columns,

  // Input streams
  input  logic                                  vector_enable,
  input  logic [DATA_SIZE-1:0]                  vector_in,
  input  logic                                  matrix_enable,
  input  logic [DATA_SIZE-1:0]                  matrix_in,

  // Product stream
  output logic                                  product_enable,
  output logic [DATA_SIZE-1:0]                  product_out,
  output logic                                  done
);

  localparam int SW         = ntm_output_pkg::SIZE_WIDTH;
  localparam int ADDR_WIDTH = (MAX_LENGTH > 1) ? $clog2(MAX_LENGTH) : 1;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic [DATA_SIZE-1:0] vector_buf [MAX_LENGTH];

  // Run phase
  logic          active;
  logic          vector_full;
  logic [SW-1:0] vec_cnt;
  logic [SW-1:0] col_cnt;
  logic [SW-1:0] row_cnt;

  logic          vector_accept;
  logic          matrix_accept;
  logic          last_column;
  logic          last_row;

  // Accumulator holds the row result in the cycle after these
  logic          row_done_q;
  logic          run_done_q;

  logic [DATA_SIZE-1:0] acc_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // Matrix words wait for the full vector
  assign vector_accept = active && !vector_full && vector_enable;
  assign matrix_accept = active && vector_full && matrix_enable;
  assign last_column   = (col_cnt == columns - 1'b1);
  assign last_row      = (row_cnt == rows - 1'b1);

  // Vector buffer write
  always_ff @(posedge CLK) begin
    if (vector_accept) begin
      vector_buf[vec_cnt[ADDR_WIDTH-1:0]] <= vector_in;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active      <= 1'b0;
      vector_full <= 1'b0;
      vec_cnt     <= '0;
      col_cnt     <= '0;
      row_cnt     <= '0;
      row_done_q  <= 1'b0;
      run_done_q  <= 1'b0;
    end else begin
      row_done_q <= matrix_accept && last_column;
      run_done_q <= matrix_accept && last_column && last_row;
      if (start) begin
        active      <= 1'b1;
        vector_full <= 1'b0;
        vec_cnt     <= '0;
        col_cnt     <= '0;
        row_cnt     <= '0;
      end else begin
        if (vector_accept) begin
          vec_cnt <= vec_cnt + 1'b1;
          if (vec_cnt == columns - 1'b1) begin
            vector_full <= 1'b1;
          end
        end
        // Column then row walk
        if (matrix_accept) begin
          if (last_column) begin
            col_cnt <= '0;
            if (last_row) begin
              row_cnt <= '0;
              active  <= 1'b0;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
      end
    end
  end

  // Column zero restarts the sum
  ntm_dot_accumulator #(
    .DATA_SIZE(DATA_SIZE)
  ) u_accumulator (
    .CLK      (CLK),
    .RST      (RST),
    .clear    (matrix_accept && (col_cnt == '0)),
    .enable   (matrix_accept),
    .data_a_in(matrix_in),
    .data_b_in(vector_buf[col_cnt[ADDR_WIDTH-1:0]]),
    .sum      (acc_sum)
  );

  // Output strobes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      product_enable <= 1'b0;
      done           <= 1'b0;
    end else begin
      product_enable <= row_done_q;
      done           <= run_done_q;
    end
  end

  // Output word, second stage
  always_ff @(posedge CLK) begin
    if (row_done_q) begin
      product_out <= acc_sum;
    end
  end

endmodule

//--- ntm_output.f
ntm_output_pkg.sv
ntm_dot_accumulator.sv
ntm_matrix_vector_product.sv
ntm_vector_summation.sv
ntm_output_vector.sv
ntm_output_tb_clock.sv
ntm_output_vector_tb.sv

//--- ntm_output_pkg.sv
// NTM output vector shared definitions
// Size counter width, run sizes struct and sequencer states

package ntm_output_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  // Width of every size field and index counter
  localparam int SIZE_WIDTH = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Run sizes, sampled on start
  typedef struct packed {
    // Rows of y
    logic [SIZE_WIDTH-1:0] size_y;
    // Length of h
    logic [SIZE_WIDTH-1:0] size_l;
    // Memory word width
    logic [SIZE_WIDTH-1:0] size_w;
    // Number of read heads
    logic [SIZE_WIDTH-1:0] size_r;
  } ntm_sizes_t;

  // Run sequencer
  typedef enum logic [1:0] {
    IDLE,
    FIRST_PRODUCT,
    SECOND_PRODUCT,
    FINISH
  } ntm_seq_state_t;

endpackage

//--- ntm_output_tb_clock.sv
// Testbench clock and reset source
// Free-running clock, reset held high for a set number of cycles

module ntm_output_tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic CLK,
  output logic RST
);

  // Half period per phase
  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Release on a rising edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

//--- ntm_output_vector.sv
// NTM controller output vector, y = K.r + U.h
// Run sequencer with size latch, two matrix-vector products and the
// element-wise summation that emits y

module ntm_output_vector #(
  parameter int DATA_SIZE  = 16,
  parameter int MAX_LENGTH = 16
) (
  input  logic                       CLK,
  input  logic                       RST,

  // Control
  input  logic                       start,
  input  ntm_output_pkg::ntm_sizes_t sizes,
  output logic                       ready,

  // Input streams
  input  logic                       r_in_enable,
  input  logic [DATA_SIZE-1:0]       r_in,
  input  logic                       k_in_enable,
  input  logic [DATA_SIZE-1:0]       k_in,
  input  logic                       h_in_enable,
  input  logic [DATA_SIZE-1:0]       h_in,
  input  logic                       u_in_enable,
  input  logic [DATA_SIZE-1:0]       u_in,

  // Output stream
  output logic                       y_out_enable,
  output logic [DATA_SIZE-1:0]       y_out
);

  localparam int SW = ntm_output_pkg::SIZE_WIDTH;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  ntm_output_pkg::ntm_seq_state_t state;
  ntm_output_pkg::ntm_sizes_t     sizes_q;

  // R.W from the live sizes, then latched
  logic [SW-1:0]   rw_in;
  logic [SW-1:0]   rw_q;
  // Words still due on the first pass
  logic [SW-1:0]   r_left;
  logic [2*SW-1:0] k_left;

  logic run_start;
  logic r_accept;
  logic k_accept;
  logic k_last;
  logic h_accept;
  logic u_accept;
  logic add_pass;

  // Product streams
  logic                 first_enable;
  logic [DATA_SIZE-1:0] first_product;
  logic                 first_done;
  logic                 second_enable;
  logic [DATA_SIZE-1:0] second_product;
  logic                 second_done;

  ////////////////////////////////////////////////////////////////////////////
  // Stream gating
  ////////////////////////////////////////////////////////////////////////////

  assign rw_in     = sizes.size_r * sizes.size_w;
  assign run_start = (state == ntm_output_pkg::IDLE) && start;

  // r first, then K, both only in the first pass
  assign r_accept = (state == ntm_output_pkg::FIRST_PRODUCT) && r_in_enable && (r_left != '0);
  assign k_accept = (state == ntm_output_pkg::FIRST_PRODUCT) && k_in_enable && (r_left == '0);
  assign k_last   = k_accept && (k_left == 'd1);

  // h before U is enforced inside the second product
  assign h_accept = (state == ntm_output_pkg::SECOND_PRODUCT) && h_in_enable;
  assign u_accept = (state == ntm_output_pkg::SECOND_PRODUCT) && u_in_enable;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ntm_output_pkg::IDLE;
      sizes_q  <= '0;
      rw_q     <= '0;
      r_left   <= '0;
      k_left   <= '0;
      add_pass <= 1'b0;
      ready    <= 1'b0;
    end else begin
      ready <= 1'b0;
      // Last first-pass element is stored, switch summation to adding
      if (first_done) begin
        add_pass <= 1'b1;
      end
      case (state)
        ntm_output_pkg::IDLE: begin
          if (start) begin
            sizes_q <= sizes;
            rw_q    <= rw_in;
            r_left  <= rw_in;
            k_left  <= sizes.size_y * rw_in;
            state   <= ntm_output_pkg::FIRST_PRODUCT;
          end
        end
        ntm_output_pkg::FIRST_PRODUCT: begin
          if (r_accept) begin
            r_left <= r_left - 1'b1;
          end
          if (k_accept) begin
            k_left <= k_left - 1'b1;
          end
          // h may follow the last K word directly
          if (k_last) begin
            state <= ntm_output_pkg::SECOND_PRODUCT;
          end
        end
        ntm_output_pkg::SECOND_PRODUCT: begin
          if (second_done) begin
            state <= ntm_output_pkg::FINISH;
          end
        end
        default: begin
          // Wait for the final y word
          if (y_out_enable) begin
            ready    <= 1'b1;
            add_pass <= 1'b0;
            state    <= ntm_output_pkg::IDLE;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // K.r over Y rows of R.W columns
  ntm_matrix_vector_product #(
    .DATA_SIZE (DATA_SIZE),
    .MAX_LENGTH(MAX_LENGTH)
  ) u_first_product (
    .CLK           (CLK),
    .RST           (RST),
    .start         (run_start),
    .rows          (sizes_q.size_y),
    .columns       (rw_q),
    .vector_enable (r_accept),
    .vector_in     (r_in),
    .matrix_enable (k_accept),
    .matrix_in     (k_in),
    .product_enable(first_enable),
    .product_out   (first_product),
    .done          (first_done)
  );

  // U.h over Y rows of L columns
  ntm_matrix_vector_product #(
    .DATA_SIZE (DATA_SIZE),
    .MAX_LENGTH(MAX_LENGTH)
  ) u_second_product (
    .CLK           (CLK),
    .RST           (RST),
    .start         (k_last),
    .rows          (sizes_q.size_y),
    .columns       (sizes_q.size_l),
    .vector_enable (h_accept),
    .vector_in     (h_in),
    .matrix_enable (u_accept),
    .matrix_in     (u_in),
    .product_enable(second_enable),
    .product_out   (second_product),
    .done          (second_done)
  );

  // The two product streams never overlap in time
  ntm_vector_summation #(
    .DATA_SIZE (DATA_SIZE),
    .MAX_LENGTH(MAX_LENGTH)
  ) u_summation (
    .CLK         (CLK),
    .RST         (RST),
    .add_pass    (add_pass),
    .data_enable (first_enable || second_enable),
    .data_in     (second_enable ? second_product : first_product),
    .y_out_enable(y_out_enable),
    .y_out       (y_out)
  );

endmodule

//--- ntm_output_vector_tb.sv
// Testbench for the NTM output vector
// Streams r, K, h and U words from the tests file, with optional gaps
// and stray words, and checks every y element and the ready pulse

module ntm_output_vector_tb;

  localparam int DATA_SIZE  = 16;
  localparam int MAX_LENGTH = 16;
  localparam int SW         = ntm_output_pkg::SIZE_WIDTH;
  localparam int CLK_PERIOD = 40;
  localparam int MAX_TESTS  = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic CLK;
  logic RST;

  logic                       start;
  ntm_output_pkg::ntm_sizes_t sizes;
  logic                       ready;
  logic                       r_in_enable;
  logic [DATA_SIZE-1:0]       r_in;
  logic                       k_in_enable;
  logic [DATA_SIZE-1:0]       k_in;
  logic                       h_in_enable;
  logic [DATA_SIZE-1:0]       h_in;
  logic                       u_in_enable;
  logic [DATA_SIZE-1:0]       u_in;
  logic                       y_out_enable;
  logic [DATA_SIZE-1:0]       y_out;

  // Test table kept flat in file order of r, K, h, U and y
  string                      test_name  [MAX_TESTS];
  ntm_output_pkg::ntm_sizes_t test_sizes [MAX_TESTS];
  int                         test_mode  [MAX_TESTS];
  int                         test_base  [MAX_TESTS];
  logic [DATA_SIZE-1:0]       word_store [$];
  int                         num_tests;

  // Monitor state
  string                cur_name;
  logic [DATA_SIZE-1:0] expected_y [$];
  logic [DATA_SIZE-1:0] exp_word;
  int                   ready_count;
  int                   runs_started;

  longint      watchdog_limit;
  int unsigned seed_value;
  int          t;
  int          i;
  logic [3:0]  stray_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Clock, reset and DUT
  ////////////////////////////////////////////////////////////////////////////

  ntm_output_tb_clock #(
    .PERIOD      (CLK_PERIOD),
    .RESET_CYCLES(4)
  ) u_clock (
    .CLK(CLK),
    .RST(RST)
  );

  ntm_output_vector #(
    .DATA_SIZE (DATA_SIZE),
    .MAX_LENGTH(MAX_LENGTH)
  ) u_dut (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .sizes       (sizes),
    .ready       (ready),
    .r_in_enable (r_in_enable),
    .r_in        (r_in),
    .k_in_enable (k_in_enable),
    .k_in        (k_in),
    .h_in_enable (h_in_enable),
    .h_in        (h_in),
    .u_in_enable (u_in_enable),
    .u_in        (u_in),
    .y_out_enable(y_out_enable),
    .y_out       (y_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  // Checks y elements in order and one ready per started run
  always @(posedge CLK) begin : y_monitor
    if (!RST) begin
      if (y_out_enable === 1'b1) begin
        if (expected_y.size() == 0) begin
          fail_run({"Test ", cur_name, " gave a y element that was not expected"});
        end else begin
          exp_word = expected_y.pop_front();
          check_value(cur_name, exp_word, y_out);
        end
      end
      if (ready === 1'b1) begin
        if (ready_count >= runs_started) begin
          fail_run({"Test ", cur_name, " gave a ready pulse that was not expected"});
        end else if (expected_y.size() != 0) begin
          fail_run({"Test ", cur_name, " pulsed ready with y elements still missing"});
        end else begin
          ready_count++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [DATA_SIZE-1:0] random_word();
    logic [31:0] value;
    value = $urandom;
    return value[DATA_SIZE-1:0];
  endfunction

  // Drives one cycle with mask bits r, K, h and U from bit 0
  task automatic drive_step(input logic [3:0] mask, input logic [DATA_SIZE-1:0] word);
    @(posedge CLK);
    start       <= 1'b0;
    r_in_enable <= mask[0];
    k_in_enable <= mask[1];
    h_in_enable <= mask[2];
    u_in_enable <= mask[3];
    r_in        <= word;
    k_in        <= word;
    h_in        <= word;
    u_in        <= word;
  endtask

  task automatic pulse_start(input ntm_output_pkg::ntm_sizes_t sz);
    @(posedge CLK);
    start       <= 1'b1;
    sizes       <= sz;
    r_in_enable <= 1'b0;
    k_in_enable <= 1'b0;
    h_in_enable <= 1'b0;
    u_in_enable <= 1'b0;
  endtask

  // Word plus 0 to 3 idle cycles when gaps are on
  task automatic send_word(input logic [3:0] mask, input logic [DATA_SIZE-1:0] word,
                           input int mode);
    int gap;
    drive_step(mask, word);
    gap = (mode != 0) ? $urandom_range(3, 0) : 0;
    repeat (gap) begin
      drive_step(4'b0000, random_word());
    end
  endtask

  task automatic send_stream(input logic [3:0] mask, input int base, input int count,
                             input int mode);
    int n;
    for (n = 0; n < count; n++) begin
      send_word(mask, word_store[base + n], mode);
    end
  endtask

  task automatic wait_ready(input int count);
    int cycles;
    cycles = 0;
    while (ready_count < count && cycles < 60) begin
      drive_step(4'b0000, random_word());
      cycles++;
    end
    if (ready_count < count) begin
      fail_run({"Test ", cur_name, " never pulsed ready after its last word"});
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests file
  ////////////////////////////////////////////////////////////////////////////

  function automatic int stream_count(input string tag, input ntm_output_pkg::ntm_sizes_t sz);
    int rw;
    rw = sz.size_r * sz.size_w;
    if (tag == "r") return rw;
    if (tag == "k") return sz.size_y * rw;
    if (tag == "h") return sz.size_l;
    if (tag == "u") return sz.size_y * sz.size_l;
    if (tag == "y") return sz.size_y;
    return -1;
  endfunction

  task automatic read_tests();
    int    fd;
    int    c;
    int    code;
    int    ny;
    int    nl;
    int    nw;
    int    nr;
    int    mode;
    int    count;
    int    n;
    string tag;
    string name;
    logic [DATA_SIZE-1:0]       word;
    ntm_output_pkg::ntm_sizes_t sz;
    fd = $fopen("ntm_output_vector_tests.txt", "r");
    if (fd == 0) begin
      fail_run("Cannot open ntm_output_vector_tests.txt");
    end
    num_tests = 0;
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        // Skip a comment to the end of its line
        c = 0;
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (tag == "test") begin
        code = $fscanf(fd, "%s %d %d %d %d %d", name, ny, nl, nw, nr, mode);
        if (code != 6 || num_tests == MAX_TESTS) begin
          fail_run("Bad test header in the tests file");
        end
        sz.size_y = ny[SW-1:0];
        sz.size_l = nl[SW-1:0];
        sz.size_w = nw[SW-1:0];
        sz.size_r = nr[SW-1:0];
        test_name[num_tests]  = name;
        test_sizes[num_tests] = sz;
        test_mode[num_tests]  = mode;
        test_base[num_tests]  = word_store.size();
        num_tests++;
      end else begin
        if (num_tests == 0) begin
          fail_run("Word list before the first test header");
        end
        count = stream_count(tag, test_sizes[num_tests - 1]);
        if (count < 0) begin
          fail_run({"Unknown tag in the tests file: ", tag});
        end
        for (n = 0; n < count; n++) begin
          code = $fscanf(fd, "%h", word);
          if (code != 1) begin
            fail_run("Tests file ended inside a word list");
          end
          word_store.push_back(word);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One run
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_test(input int idx);
    ntm_output_pkg::ntm_sizes_t sz;
    ntm_output_pkg::ntm_sizes_t junk;
    int rw;
    int ny;
    int nl;
    int base;
    int mode;
    int n;
    sz   = test_sizes[idx];
    mode = test_mode[idx];
    base = test_base[idx];
    ny   = sz.size_y;
    nl   = sz.size_l;
    rw   = sz.size_r * sz.size_w;
    cur_name = test_name[idx];
    for (n = 0; n < ny; n++) begin
      expected_y.push_back(word_store[base + rw + ny * rw + nl + ny * nl + n]);
    end
    runs_started++;
    pulse_start(sz);
    // Mode 2 adds words on streams not due yet
    if (mode == 2) begin
      drive_step(4'b0010, random_word());
      drive_step(4'b0100, random_word());
      drive_step(4'b1000, random_word());
    end
    send_stream(4'b0001, base, rw, mode);
    send_stream(4'b0010, base + rw, ny * rw, mode);
    if (mode == 2) begin
      drive_step(4'b0001, random_word());
      drive_step(4'b0010, random_word());
      drive_step(4'b1000, random_word());
      // Start in mid run with other sizes
      junk = $urandom;
      pulse_start(junk);
    end
    send_stream(4'b0100, base + rw + ny * rw, nl, mode);
    send_stream(4'b1000, base + rw + ny * rw + nl, ny * nl, mode);
    if (mode == 2) begin
      drive_step(4'b0001, random_word());
      drive_step(4'b0100, random_word());
      drive_step(4'b1000, random_word());
    end
    wait_ready(idx + 1);
    // Idle cycles where a second ready of this run would show
    repeat (3) begin
      drive_step(4'b0000, random_word());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    start       = 1'b0;
    sizes       = '0;
    r_in_enable = 1'b0;
    r_in        = '0;
    k_in_enable = 1'b0;
    k_in        = '0;
    h_in_enable = 1'b0;
    h_in        = '0;
    u_in_enable = 1'b0;
    u_in        = '0;
    ready_count    = 0;
    runs_started   = 0;
    cur_name       = "after_reset";
    watchdog_limit = 0;
    seed_value     = $urandom(32'h4d81);
    read_tests();
    watchdog_limit = (longint'(word_store.size()) * 5 + 50 * num_tests) * CLK_PERIOD;
    wait (RST === 1'b0);
    // Idle outputs with stray words before any start
    for (i = 0; i < 6; i++) begin
      stray_mask = 4'($urandom_range(15, 0));
      drive_step(stray_mask, random_word());
      check_value("after_reset ready", 0, ready);
      check_value("after_reset y_out_enable", 0, y_out_enable);
      check_value("after_reset y_out", 0, y_out);
    end
    for (t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin : watchdog
    wait (watchdog_limit > 0);
    #(watchdog_limit);
    $display("Timeout, the run did not finish within %0d time units", watchdog_limit);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- ntm_output_vector_tests.txt
# test <name> <size_y> <size_l> <size_w> <size_r> <gaps: 0 none, 1 random, 2 random + strays>
# then tags r, k (row-major), h, u (row-major) and expected y, each with its hex words
test small_hand 2 1 2 1 0
r 0001 0002
k 0003 0004
  0005 0006
h 0007
u 0008
  0009
y 0043 0050
test random_gaps 3 2 2 2 1
r 0001 0002 0003 0004
k 0001 0000 0002 0001
  0002 0002 0002 0002
  0000 0001 0000 0003
h 0005 0006
u 0001 0001
  0002 0000
  0000 0003
y 0016 001e 0020
test wrap_large 2 2 1 2 1
r ffff 8000
k ffff 0002
  ffff ffff
h 1234 ffff
u 0010 ffff
  fffe 0001
y 2342 5b98
test full_size_strays 4 4 4 2 2
r 0001 0002 0003 0004 0005 0006 0007 0008
k 0001 0001 0001 0001 0001 0001 0001 0001
  0001 0000 0000 0000 0000 0000 0000 0001
  0002 0000 0000 0000 0000 0000 0000 0000
  0000 0000 0000 0000 0000 0000 0000 000a
h 000a 0014 001e 0028
u 0001 0000 0000 0000
  0000 0001 0000 0000
  0001 0001 0001 0001
  0000 0000 0000 0002
y 002e 001d 0066 00a0
test single_after_big 1 1 1 1 1
r 0003
k 0005
h 0002
u 0007
y 001d
test small_strays 2 1 2 1 2
r 0001 0002
k 0003 0004
  0005 0006
h 0007
u 0008
  0009
y 0043 0050

//--- ntm_vector_summation.sv
// Element-wise vector summation of two product streams
// Store pass keeps the first vector, add pass adds the second to it
// and emits each wrapped sum

module ntm_vector_summation #(
  parameter int DATA_SIZE  = 16,
  parameter int MAX_LENGTH = 16
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Pass select, low stores and high adds
  input  logic                 add_pass,

  // Element stream in
  input  logic                 data_enable,
  input  logic [DATA_SIZE-1:0] data_in,

  // Result stream
  output logic                 y_out_enable,
  output logic [DATA_SIZE-1:0] y_out
);

  localparam int SW         = ntm_output_pkg::SIZE_WIDTH;
  localparam int ADDR_WIDTH = (MAX_LENGTH > 1) ? $clog2(MAX_LENGTH) : 1;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic [DATA_SIZE-1:0] stored [MAX_LENGTH];

  logic          add_pass_q;
  logic [SW-1:0] row_idx;
  // Index in use this cycle
  logic [SW-1:0] row_sel;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // Pass change restarts at row zero, even with an element in the same cycle
  assign row_sel = (add_pass != add_pass_q) ? '0 : row_idx;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      add_pass_q <= 1'b0;
      row_idx    <= '0;
    end else begin
      add_pass_q <= add_pass;
      row_idx    <= row_sel + SW'(data_enable);
    end
  end

  // First vector buffer
  always_ff @(posedge CLK) begin
    if (data_enable && !add_pass) begin
      stored[row_sel[ADDR_WIDTH-1:0]] <= data_in;
    end
  end

  // Sum register, one cycle after each second element
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      y_out_enable <= 1'b0;
      y_out        <= '0;
    end else begin
      y_out_enable <= data_enable && add_pass;
      if (data_enable && add_pass) begin
        y_out <= stored[row_sel[ADDR_WIDTH-1:0]] + data_in;
      end
    end
  end

endmodule
